//--- Makefile
TOP = rot_entropy_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- design/edn_dist.sv
`timescale 1ns/1ps
`default_nettype none

`include "rot_consts.svh"

module edn_dist
  import rot_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          empty_i,
  input  entropy_word_t head_i,
  output logic          pop_o,
  input  ep_vec_t       ep_req_i,
  output ep_vec_t       ep_ack_o,
  output entropy_word_t ep_bus_o
);

  edn_state_e    state_q;
  ep_idx_t       last_q;
  ep_idx_t       grant_idx;
  logic          grant_found;
  ep_vec_t       ack_q;
  entropy_word_t bus_q;

  // round robin search, starting just after the last granted endpoint
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = last_q;
    for (int i = 1; i <= `ROT_NUM_EP; i++) begin
      if (!grant_found && ep_req_i[ep_idx_t'(last_q + i)]) begin
        grant_found = 1'b1;
        grant_idx   = ep_idx_t'(last_q + i);
      end
    end
  end

  // grant only from idle with a word waiting
  assign pop_o = (state_q == EDN_IDLE) && !empty_i && grant_found;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= EDN_IDLE;
      // so endpoint 0 comes first after reset
      last_q  <= ep_idx_t'(`ROT_NUM_EP - 1);
      ack_q   <= '0;
    end else begin
      // ack is a single cycle pulse
      ack_q <= '0;
      case (state_q)
        EDN_IDLE: begin
          if (pop_o) begin
            ack_q   <= ep_vec_t'(1) << grant_idx;
            last_q  <= grant_idx;
            state_q <= EDN_ACK;
          end
        end
        EDN_ACK: begin
          // endpoint drops its request during the gap
          state_q <= EDN_GAP;
        end
        EDN_GAP: begin
          state_q <= EDN_IDLE;
        end
        default: begin
          state_q <= EDN_IDLE;
        end
      endcase
    end
  end

  // shared data bus, valid together with the ack
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      bus_q <= head_i;
    end
  end

  assign ep_ack_o = ack_q;
  assign ep_bus_o = bus_q;

endmodule

`default_nettype wire

//--- design/es_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "rot_consts.svh"

module es_collector
  import rot_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          puf_rng_mode_i,
  input  sample_t       puf_rng_i,
  input  logic          puf_rng_valid_i,
  input  sample_t       ext_rng_i,
  input  logic          ext_rng_valid_i,
  input  logic          fifo_full_i,
  output logic          push_o,
  output entropy_word_t push_word_o,
  output logic          es_rng_enable_o,
  output logic          intr_entropy_valid_o,
  output logic          intr_health_test_failed_o,
  output logic          intr_fifo_overflow_o
);

  typedef logic [$clog2(`ROT_REP_LIMIT+1)-1:0] run_cnt_t;
  typedef logic [$clog2(`ROT_SAMPLES_PER_WORD)-1:0] smp_cnt_t;

  sample_t       sel_sample;
  logic          sel_valid;
  sample_t       last_sample_q;
  run_cnt_t      run_cnt_q;
  run_cnt_t      run_next;
  smp_cnt_t      smp_cnt_q;
  entropy_word_t word_q;
  entropy_word_t word_next;
  logic          health_fail;
  logic          word_done;
  logic          push_q;
  logic          fail_q;
  logic          ovf_q;
  logic          rdy_q;

  // PUF in rng mode wins, otherwise the external rng
  assign sel_sample = puf_rng_mode_i ? puf_rng_i : ext_rng_i;
  assign sel_valid  = puf_rng_mode_i ? puf_rng_valid_i : ext_rng_valid_i;

  always_comb begin
    // run length including this sample, zero count means no run yet
    if (run_cnt_q != '0 && sel_sample == last_sample_q) begin
      run_next = run_cnt_q + run_cnt_t'(1);
    end else begin
      run_next = run_cnt_t'(1);
    end
    health_fail = sel_valid && (run_next == run_cnt_t'(`ROT_REP_LIMIT));
    // eighth good sample closes the word
    word_done = sel_valid && !health_fail &&
                (smp_cnt_q == smp_cnt_t'(`ROT_SAMPLES_PER_WORD - 1));
    // shift in from the top so the first sample lands in the low bits
    word_next = {sel_sample, word_q[`ROT_WORD_W-1:`ROT_SAMPLE_W]};
  end

  // word goes straight into the FIFO at the completing edge
  assign push_o      = word_done && !fifo_full_i;
  assign push_word_o = word_next;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_cnt_q <= '0;
      smp_cnt_q <= '0;
      push_q    <= 1'b0;
      fail_q    <= 1'b0;
      ovf_q     <= 1'b0;
      rdy_q     <= 1'b0;
    end else begin
      rdy_q  <= 1'b1;
      // interrupt pulses, one cycle after the event
      push_q <= push_o;
      fail_q <= health_fail;
      ovf_q  <= word_done && fifo_full_i;
      if (health_fail) begin
        // drop partial word, next sample starts a new run
        run_cnt_q <= '0;
        smp_cnt_q <= '0;
      end else if (sel_valid) begin
        run_cnt_q <= run_next;
        smp_cnt_q <= word_done ? '0 : smp_cnt_q + smp_cnt_t'(1);
      end
    end
  end

  // sample history and partial word
  always_ff @(posedge clk_i) begin
    if (sel_valid) begin
      last_sample_q <= sel_sample;
      word_q        <= word_next;
    end
  end

  // rng runs while there is room for another word
  assign es_rng_enable_o           = rdy_q && !fifo_full_i;
  assign intr_entropy_valid_o      = push_q;
  assign intr_health_test_failed_o = fail_q;
  assign intr_fifo_overflow_o      = ovf_q;

endmodule

`default_nettype wire

//--- design/es_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "rot_consts.svh"

module es_fifo
  import rot_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          push_i,
  input  entropy_word_t push_word_i,
  input  logic          pop_i,
  output entropy_word_t head_o,
  output logic          full_o,
  output logic          empty_o
);

  typedef logic [$clog2(`ROT_FIFO_DEPTH)-1:0] ptr_t;

  entropy_word_t mem_q [`ROT_FIFO_DEPTH];
  ptr_t          wr_ptr_q;
  ptr_t          rd_ptr_q;
  fifo_cnt_t     cnt_q;
  logic          do_push;
  logic          do_pop;

  // ignore a push into a full buffer or a pop from an empty one
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(`ROT_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(`ROT_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + fifo_cnt_t'(1);
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - fifo_cnt_t'(1);
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_word_i;
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign full_o  = (cnt_q == fifo_cnt_t'(`ROT_FIFO_DEPTH));
  assign empty_o = (cnt_q == '0);

endmodule

`default_nettype wire

//--- design/rot_consts.svh
`ifndef ROT_CONSTS_SVH
`define ROT_CONSTS_SVH

// raw noise sample width from either source
`define ROT_SAMPLE_W 4
// packed entropy word handed to endpoints
`define ROT_WORD_W 32
// samples needed to fill one word
`define ROT_SAMPLES_PER_WORD 8
// entropy FIFO depth, in words
`define ROT_FIFO_DEPTH 4
// hardware endpoints behind the EDN
`define ROT_NUM_EP 4
// identical consecutive samples that fail the health test
`define ROT_REP_LIMIT 6

`endif

//--- design/rot_entropy_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rot_consts.svh"

module rot_entropy_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // noise sources
  input  logic                       puf_rng_mode_i,
  input  logic [`ROT_SAMPLE_W-1:0]   puf_rng_i,
  input  logic                       puf_rng_valid_i,
  input  logic [`ROT_SAMPLE_W-1:0]   ext_rng_i,
  input  logic                       ext_rng_valid_i,
  output logic                       es_rng_enable_o,
  // endpoint side
  input  logic [`ROT_NUM_EP-1:0]     ep_req_i,
  output logic [`ROT_NUM_EP-1:0]     ep_ack_o,
  output logic [`ROT_WORD_W-1:0]     ep_bus_o,
  // interrupts
  output logic                       intr_entropy_valid_o,
  output logic                       intr_health_test_failed_o,
  output logic                       intr_fifo_overflow_o
);

  // collector to FIFO
  logic                   push;
  logic [`ROT_WORD_W-1:0] push_word;
  logic                   full;
  // FIFO to EDN
  logic                   pop;
  logic [`ROT_WORD_W-1:0] head;
  logic                   empty;

  es_collector u_es_collector (
    .clk_i                     (clk_i),
    .rst_i                     (rst_i),
    .puf_rng_mode_i            (puf_rng_mode_i),
    .puf_rng_i                 (puf_rng_i),
    .puf_rng_valid_i           (puf_rng_valid_i),
    .ext_rng_i                 (ext_rng_i),
    .ext_rng_valid_i           (ext_rng_valid_i),
    .fifo_full_i               (full),
    .push_o                    (push),
    .push_word_o               (push_word),
    .es_rng_enable_o           (es_rng_enable_o),
    .intr_entropy_valid_o      (intr_entropy_valid_o),
    .intr_health_test_failed_o (intr_health_test_failed_o),
    .intr_fifo_overflow_o      (intr_fifo_overflow_o)
  );

  es_fifo u_es_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (push),
    .push_word_i (push_word),
    .pop_i       (pop),
    .head_o      (head),
    .full_o      (full),
    .empty_o     (empty)
  );

  edn_dist u_edn_dist (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .empty_i  (empty),
    .head_i   (head),
    .pop_o    (pop),
    .ep_req_i (ep_req_i),
    .ep_ack_o (ep_ack_o),
    .ep_bus_o (ep_bus_o)
  );

endmodule

`default_nettype wire

//--- design/rot_pkg.sv
`default_nettype none

`include "rot_consts.svh"

package rot_pkg;

  // one raw noise sample
  typedef logic [`ROT_SAMPLE_W-1:0] sample_t;
  // one packed entropy word
  typedef logic [`ROT_WORD_W-1:0] entropy_word_t;
  // one bit per endpoint
  typedef logic [`ROT_NUM_EP-1:0] ep_vec_t;
  // endpoint number
  typedef logic [$clog2(`ROT_NUM_EP)-1:0] ep_idx_t;
  // FIFO occupancy, needs room for the full count
  typedef logic [$clog2(`ROT_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  // distribution FSM: grant, ack pulse, one idle gap
  typedef enum logic [1:0] {
    EDN_IDLE,
    EDN_ACK,
    EDN_GAP
  } edn_state_e;

endpackage

`default_nettype wire

//--- dv/rot_entropy_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "rot_consts.svh"

module rot_entropy_sva (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic [`ROT_NUM_EP-1:0] req_i,
  input logic [`ROT_NUM_EP-1:0] ack_i,
  input logic                   push_i,
  input logic                   pop_i,
  input logic                   full_i,
  input logic                   rng_enable_i
);

  // failed assertions so far, summed into the testbench error count
  int fail_cnt = 0;

  // one endpoint served per ack
  ack_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(ack_i))
    else begin
      $error("ack raised on more than one endpoint");
      fail_cnt++;
    end

  // ack only toward a requesting endpoint
  ack_req_a: assert property (@(posedge clk_i) disable iff (rst_i) (ack_i & ~req_i) == '0)
    else begin
      $error("ack raised on an endpoint without a request");
      fail_cnt++;
    end

  // no push into a full FIFO unless a pop frees a slot
  push_full_a: assert property (@(posedge clk_i) disable iff (rst_i) push_i && full_i |-> pop_i)
    else begin
      $error("push while the FIFO is full");
      fail_cnt++;
    end

  // noise source held off while full
  enable_full_a: assert property (@(posedge clk_i) disable iff (rst_i) full_i |-> !rng_enable_i)
    else begin
      $error("rng enable high with a full FIFO");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- dv/rot_entropy_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rot_consts.svh"

module rot_entropy_tb
  import rot_pkg::*;
();

  // samples over all tests set the watchdog length
  localparam int TOTAL_SAMPLES = 64 + 32 + 23 + 32 + 48;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 4 + 500;

  logic          clk;
  logic          rst;
  logic          puf_rng_mode;
  sample_t       puf_rng;
  logic          puf_rng_valid;
  sample_t       ext_rng;
  logic          ext_rng_valid;
  logic          es_rng_enable;
  ep_vec_t       ep_req;
  ep_vec_t       ep_ack;
  entropy_word_t ep_bus;
  logic          intr_valid;
  logic          intr_fail;
  logic          intr_ovf;

  logic [31:0]   lfsr_q;
  sample_t       gen_q[$];
  entropy_word_t exp_q[$];
  ep_vec_t       ack_order[$];
  int            error_cnt;
  int            valid_cnt;
  int            fail_cnt;
  int            ovf_cnt;
  int            ack_cnt;

  rot_entropy_top u_rot_entropy_top (
    .clk_i                     (clk),
    .rst_i                     (rst),
    .puf_rng_mode_i            (puf_rng_mode),
    .puf_rng_i                 (puf_rng),
    .puf_rng_valid_i           (puf_rng_valid),
    .ext_rng_i                 (ext_rng),
    .ext_rng_valid_i           (ext_rng_valid),
    .es_rng_enable_o           (es_rng_enable),
    .ep_req_i                  (ep_req),
    .ep_ack_o                  (ep_ack),
    .ep_bus_o                  (ep_bus),
    .intr_entropy_valid_o      (intr_valid),
    .intr_health_test_failed_o (intr_fail),
    .intr_fifo_overflow_o      (intr_ovf)
  );

  bind rot_entropy_top rot_entropy_sva u_sva (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (ep_req_i),
    .ack_i        (ep_ack_o),
    .push_i       (push),
    .pop_i        (pop),
    .full_i       (full),
    .rng_enable_i (es_rng_enable_o)
  );

  always #50 clk = ~clk;

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
      error_cnt++;
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic sample_t rand_sample();
    sample_t v;
    v = '0;
    for (int b = 0; b < `ROT_SAMPLE_W; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[`ROT_SAMPLE_W-2:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic add_random(input int n);
    sample_t s;
    for (int k = 0; k < n; k++) begin
      s = rand_sample();
      // neighbours kept distinct so no runs form
      if (gen_q.size() != 0 && s == gen_q[$]) begin
        s = s ^ sample_t'(1);
      end
      gen_q.push_back(s);
    end
  endtask

  // expected words from gen_q packed low bits first under the repetition rule
  function automatic int pack_ref();
    entropy_word_t word;
    sample_t       last;
    int            run;
    int            cnt;
    int            fails;
    word = '0;
    last = '0;
    run = 0;
    cnt = 0;
    fails = 0;
    foreach (gen_q[k]) begin
      if (run != 0 && gen_q[k] == last) begin
        run++;
      end else begin
        run = 1;
      end
      last = gen_q[k];
      if (run == `ROT_REP_LIMIT) begin
        // sample and partial word lost and the run starts over
        fails++;
        run = 0;
        cnt = 0;
      end else begin
        word[cnt*`ROT_SAMPLE_W +: `ROT_SAMPLE_W] = gen_q[k];
        cnt++;
        if (cnt == `ROT_SAMPLES_PER_WORD) begin
          exp_q.push_back(word);
          cnt = 0;
        end
      end
    end
    return fails;
  endfunction

  task automatic reset_dut();
    @(negedge clk);
    rst = 1'b1;
    ep_req = '0;
    puf_rng_mode = 1'b0;
    puf_rng_valid = 1'b0;
    ext_rng_valid = 1'b0;
    repeat (2) @(negedge clk);
    // everything quiet in reset
    check_eq(32'(ep_ack), 32'h0, "ack during reset");
    check_eq(32'(es_rng_enable), 32'h0, "rng enable during reset");
    check_eq(32'({intr_valid, intr_fail, intr_ovf}), 32'h0, "interrupts during reset");
    rst = 1'b0;
    gen_q.delete();
    exp_q.delete();
    ack_order.delete();
    valid_cnt = 0;
    fail_cnt = 0;
    ovf_cnt = 0;
    ack_cnt = 0;
  endtask

  // one sample per cycle from the chosen source
  task automatic drive_samples(input logic puf_mode);
    foreach (gen_q[k]) begin
      @(negedge clk);
      puf_rng_mode = puf_mode;
      if (puf_mode) begin
        puf_rng = gen_q[k];
        puf_rng_valid = 1'b1;
        // noise on the unused source
        ext_rng = rand_sample();
        ext_rng_valid = 1'b1;
      end else begin
        ext_rng = gen_q[k];
        ext_rng_valid = 1'b1;
        puf_rng_valid = 1'b0;
      end
    end
    @(negedge clk);
    puf_rng_valid = 1'b0;
    ext_rng_valid = 1'b0;
  endtask

  // wait for every expected word plus a margin for stray pulses
  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
  endtask

  // outputs sampled at the falling edge where they are stable
  always @(negedge clk) begin
    if (!rst) begin
      if (intr_valid) valid_cnt++;
      if (intr_fail) fail_cnt++;
      if (intr_ovf) ovf_cnt++;
      if (ep_ack != '0) begin
        ack_cnt++;
        ack_order.push_back(ep_ack);
        if (exp_q.size() == 0) begin
          $display("unexpected acknowledge at %0t, no word was expected", $time);
          error_cnt++;
        end else begin
          check_eq(ep_bus, exp_q.pop_front(), "delivered word");
        end
      end
    end
  end

  initial begin
    int n_words;
    clk = 1'b0;
    rst = 1'b1;
    puf_rng_mode = 1'b0;
    puf_rng = '0;
    puf_rng_valid = 1'b0;
    ext_rng = '0;
    ext_rng_valid = 1'b0;
    ep_req = '0;
    lfsr_q = 32'h24bd1b3f;
    error_cnt = 0;

    // external source with all endpoints asking
    reset_dut();
    add_random(64);
    void'(pack_ref());
    n_words = exp_q.size();
    ep_req = 4'hf;
    drive_samples(1'b0);
    wait_drain();
    check_eq(ack_cnt, n_words, "acks, external source");
    check_eq(valid_cnt, n_words, "entropy valid pulses");
    check_eq(fail_cnt, 0, "health pulses, random run");

    // PUF source while ext carries noise
    reset_dut();
    add_random(32);
    void'(pack_ref());
    n_words = exp_q.size();
    ep_req = 4'hf;
    drive_samples(1'b1);
    wait_drain();
    check_eq(ack_cnt, n_words, "acks, PUF source");

    // one stray sample before a run that hits the limit
    reset_dut();
    add_random(1);
    for (int k = 0; k < `ROT_REP_LIMIT; k++) begin
      gen_q.push_back(gen_q[0] ^ sample_t'(8));
    end
    add_random(16);
    void'(pack_ref());
    ep_req = 4'hf;
    drive_samples(1'b0);
    wait_drain();
    check_eq(fail_cnt, 1, "health failure pulses");
    check_eq(valid_cnt, 2, "words after health failure");

    // endpoints 0 and 2 only
    reset_dut();
    add_random(32);
    void'(pack_ref());
    ep_req = 4'b0101;
    drive_samples(1'b0);
    wait_drain();
    check_eq(ack_order.size(), 4, "acks to endpoints 0 and 2");
    foreach (ack_order[k]) begin
      check_eq(32'(ack_order[k]), (k % 2 == 0) ? 32'h1 : 32'h4, "round robin order");
    end

    // six words into a four deep FIFO with no requests
    reset_dut();
    add_random(48);
    void'(pack_ref());
    while (exp_q.size() > `ROT_FIFO_DEPTH) begin
      void'(exp_q.pop_back());
    end
    drive_samples(1'b0);
    // overflow pulse lands one cycle after the last word
    @(negedge clk);
    check_eq(ovf_cnt, 2, "overflow pulses");
    check_eq(valid_cnt, `ROT_FIFO_DEPTH, "words stored");
    check_eq(32'(es_rng_enable), 32'h0, "rng enable with full FIFO");
    check_eq(ack_cnt, 0, "acks without requests");
    ep_req = 4'hf;
    wait_drain();
    check_eq(ack_cnt, `ROT_FIFO_DEPTH, "words delivered after overflow");
    // FIFO drained so the noise source runs again
    check_eq(32'(es_rng_enable), 32'h1, "rng enable with empty FIFO");

    error_cnt += u_rot_entropy_top.u_sva.fail_cnt;
    $display("run complete, %0d errors", error_cnt);
    if (error_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("run aborted, %0d errors", error_cnt + 1);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/rot_pkg.sv
design/es_collector.sv
design/es_fifo.sv
design/edn_dist.sv
design/rot_entropy_top.sv
dv/rot_entropy_sva.sv
dv/rot_entropy_tb.sv
